// ==== common/udp_pkg.sv ====
// UDP header and configuration types
package udp_pkg;

    typedef logic [15:0] port_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_len_t;

    // Header fields handed over by the stack with each received frame
    typedef struct packed {
        ip_addr_t source_ip;
        port_t    source_port;
        port_t    dest_port;
        udp_len_t length;
    } udp_rx_hdr_t;

    // Header presented to the stack for each transmitted frame
    typedef struct packed {
        ip_addr_t source_ip;
        ip_addr_t dest_ip;
        port_t    source_port;
        port_t    dest_port;
        udp_len_t length;
    } udp_tx_hdr_t;

    typedef struct packed {
        ip_addr_t local_ip;
        ip_addr_t tx_dest_ip;
        port_t    tx_source_port;
        port_t    tx_dest_port;
        port_t    rx_dest_port;
    } udp_cfg_t;

    // Length field counts the 8-byte UDP header too
    localparam udp_len_t UDP_HDR_LEN = udp_len_t'(8);

endpackage

// ==== common/stream_pkg.sv ====
// Byte stream beat type
package stream_pkg;

    // One payload byte with its frame markers
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } beat_t;

endpackage

// ==== source/byte_fifo.sv ====
// Stream beat FIFO
`timescale 1ns/1ps

module byte_fifo #(
    parameter int DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  stream_pkg::beat_t in_beat,
    input  logic              in_valid,
    output logic              in_ready,
    output stream_pkg::beat_t out_beat,
    output logic              out_valid,
    input  logic              out_ready
);

    localparam int AW = $clog2(DEPTH);

    stream_pkg::beat_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign in_ready  = (count != DEPTH[AW:0]);
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // A written beat reaches the read side one cycle later
    assign out_beat = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rx/udp_port_filter.sv ====
// RX destination port filter
`timescale 1ns/1ps

module udp_port_filter (
    input  logic                clk,
    input  logic                rst,
    input  udp_pkg::port_t      rx_dest_port,
    input  udp_pkg::udp_rx_hdr_t hdr,
    input  logic                hdr_valid,
    output logic                hdr_ready,
    input  stream_pkg::beat_t   in_beat,
    input  logic                in_valid,
    output logic                in_ready,
    output stream_pkg::beat_t   out_beat,
    output logic                out_valid,
    input  logic                out_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PASS,
        ST_DROP
    } state_t;

    state_t state;
    logic   last_accept;

    assign hdr_ready = (state == ST_IDLE);

    // Payload is steered without a register stage
    assign out_beat  = in_beat;
    assign out_valid = in_valid && (state == ST_PASS);
    assign in_ready  = ((state == ST_PASS) && out_ready) || (state == ST_DROP);

    assign last_accept = in_valid && in_ready && in_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_valid) begin
                        state <= (hdr.dest_port == rx_dest_port) ? ST_PASS : ST_DROP;
                    end
                end
                ST_PASS, ST_DROP: begin
                    if (last_accept) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== tx/udp_tx_framer.sv ====
// TX frame length counter and header source
`timescale 1ns/1ps

module udp_tx_framer #(
    parameter int LEN_QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  udp_pkg::udp_cfg_t    cfg,
    input  stream_pkg::beat_t    in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    output stream_pkg::beat_t    out_beat,
    output logic                 out_valid,
    input  logic                 out_ready,
    output udp_pkg::udp_tx_hdr_t hdr,
    output logic                 hdr_valid,
    input  logic                 hdr_ready
);

    localparam int QW = $clog2(LEN_QUEUE_DEPTH);

    udp_pkg::udp_len_t len_q [LEN_QUEUE_DEPTH];

    logic [QW-1:0]     q_wr;
    logic [QW-1:0]     q_rd;
    logic [QW:0]       q_count;
    logic              q_full;
    logic              accept;
    logic              push;
    logic              pop;
    udp_pkg::udp_len_t frame_count;

    assign q_full = (q_count == LEN_QUEUE_DEPTH[QW:0]);

    // No room for another length entry holds the user side off
    assign out_beat  = in_beat;
    assign out_valid = in_valid && !q_full;
    assign in_ready  = out_ready && !q_full;

    assign accept = in_valid && in_ready;
    assign push   = accept && in_beat.last;
    assign pop    = hdr_valid && hdr_ready;

    assign hdr_valid          = (q_count != '0);
    assign hdr.source_ip      = cfg.local_ip;
    assign hdr.dest_ip        = cfg.tx_dest_ip;
    assign hdr.source_port    = cfg.tx_source_port;
    assign hdr.dest_port      = cfg.tx_dest_port;
    assign hdr.length         = len_q[q_rd];

    always_ff @(posedge clk) begin
        if (push) begin
            len_q[q_wr] <= frame_count + udp_pkg::udp_len_t'(1) + udp_pkg::UDP_HDR_LEN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_count <= '0;
            q_wr        <= '0;
            q_rd        <= '0;
            q_count     <= '0;
        end else begin
            if (push) begin
                frame_count <= '0;
                q_wr        <= q_wr + 1'b1;
            end else if (accept) begin
                frame_count <= frame_count + 1'b1;
            end
            if (pop) begin
                q_rd <= q_rd + 1'b1;
            end
            case ({push, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

endmodule

// ==== source/udp_connection.sv ====
// UDP stream connection top level
`timescale 1ns/1ps

module udp_connection #(
    parameter int RX_FIFO_DEPTH   = 64,
    parameter int TX_FIFO_DEPTH   = 64,
    parameter int LEN_QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  udp_pkg::udp_cfg_t    cfg,

    // Stack RX
    input  udp_pkg::udp_rx_hdr_t rx_hdr,
    input  logic                 rx_hdr_valid,
    output logic                 rx_hdr_ready,
    input  stream_pkg::beat_t    rx_in,
    input  logic                 rx_in_valid,
    output logic                 rx_in_ready,

    // User RX
    output stream_pkg::beat_t    rx_out,
    output logic                 rx_out_valid,
    input  logic                 rx_out_ready,

    // User TX
    input  stream_pkg::beat_t    tx_in,
    input  logic                 tx_in_valid,
    output logic                 tx_in_ready,

    // Stack TX
    output udp_pkg::udp_tx_hdr_t tx_hdr,
    output logic                 tx_hdr_valid,
    input  logic                 tx_hdr_ready,
    output stream_pkg::beat_t    tx_out,
    output logic                 tx_out_valid,
    input  logic                 tx_out_ready
);

    stream_pkg::beat_t filt_beat;
    logic              filt_valid;
    logic              filt_ready;

    stream_pkg::beat_t frm_beat;
    logic              frm_valid;
    logic              frm_ready;

    udp_port_filter filter (
        .clk          (clk),
        .rst          (rst),
        .rx_dest_port (cfg.rx_dest_port),
        .hdr          (rx_hdr),
        .hdr_valid    (rx_hdr_valid),
        .hdr_ready    (rx_hdr_ready),
        .in_beat      (rx_in),
        .in_valid     (rx_in_valid),
        .in_ready     (rx_in_ready),
        .out_beat     (filt_beat),
        .out_valid    (filt_valid),
        .out_ready    (filt_ready)
    );

    byte_fifo #(
        .DEPTH (RX_FIFO_DEPTH)
    ) rx_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (filt_beat),
        .in_valid  (filt_valid),
        .in_ready  (filt_ready),
        .out_beat  (rx_out),
        .out_valid (rx_out_valid),
        .out_ready (rx_out_ready)
    );

    // Store-and-forward length count at the FIFO input
    udp_tx_framer #(
        .LEN_QUEUE_DEPTH (LEN_QUEUE_DEPTH)
    ) framer (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .in_beat   (tx_in),
        .in_valid  (tx_in_valid),
        .in_ready  (tx_in_ready),
        .out_beat  (frm_beat),
        .out_valid (frm_valid),
        .out_ready (frm_ready),
        .hdr       (tx_hdr),
        .hdr_valid (tx_hdr_valid),
        .hdr_ready (tx_hdr_ready)
    );

    byte_fifo #(
        .DEPTH (TX_FIFO_DEPTH)
    ) tx_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (frm_beat),
        .in_valid  (frm_valid),
        .in_ready  (frm_ready),
        .out_beat  (tx_out),
        .out_valid (tx_out_valid),
        .out_ready (tx_out_ready)
    );

endmodule

// ==== sim/udp_checker.sv ====
// Stream and header checker
`timescale 1ns/1ps

module udp_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 rx_hdr_ready,
    input stream_pkg::beat_t    rx_out,
    input logic                 rx_out_valid,
    input logic                 rx_out_ready,
    input stream_pkg::beat_t    tx_out,
    input logic                 tx_out_valid,
    input logic                 tx_out_ready,
    input udp_pkg::udp_tx_hdr_t tx_hdr,
    input logic                 tx_hdr_valid,
    input logic                 tx_hdr_ready
);

    stream_pkg::beat_t    exp_rx [$];
    stream_pkg::beat_t    exp_tx [$];
    udp_pkg::udp_tx_hdr_t exp_hdr [$];

    int error_count = 0;
    int test_errors = 0;
    int pass_count  = 0;
    int fail_count  = 0;

    task automatic expect_rx(input stream_pkg::beat_t b);
        exp_rx.push_back(b);
    endtask

    task automatic expect_tx(input stream_pkg::beat_t b);
        exp_tx.push_back(b);
    endtask

    task automatic expect_hdr(input udp_pkg::udp_tx_hdr_t h);
        exp_hdr.push_back(h);
    endtask

    function automatic int pending();
        return exp_rx.size() + exp_tx.size() + exp_hdr.size();
    endfunction

    task automatic note_error();
        error_count = error_count + 1;
        test_errors = test_errors + 1;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            note_error();
        end
    endtask

    task automatic compare_beat(input string name, input stream_pkg::beat_t exp,
                                input stream_pkg::beat_t act);
        check_value({name, ".data"}, exp.data, act.data);
        check_value({name, ".last"}, exp.last, act.last);
        check_value({name, ".user"}, exp.user, act.user);
    endtask

    task automatic check_reset_state();
        check_value("rx_out_valid", 0, rx_out_valid);
        check_value("tx_out_valid", 0, tx_out_valid);
        check_value("tx_hdr_valid", 0, tx_hdr_valid);
        check_value("rx_hdr_ready", 1, rx_hdr_ready);
    endtask

    task automatic end_test(input int id, input string name);
        if (test_errors == 0) begin
            $display("PASS test %0d %s", id, name);
            pass_count = pass_count + 1;
        end else begin
            $display("FAIL test %0d %s with %0d mismatches", id, name, test_errors);
            fail_count = fail_count + 1;
        end
        test_errors = 0;
    endtask

    task automatic report_missing();
        if (pending() != 0) begin
            $display("Frames left missing: %0d RX beats, %0d TX beats, %0d TX headers",
                     exp_rx.size(), exp_tx.size(), exp_hdr.size());
            note_error();
        end
    endtask

    task automatic report_counts();
        $display("Tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, error_count);
    endtask

    // Handshakes sampled at the falling edge
    always @(negedge clk) begin : watch_ports
        udp_pkg::udp_tx_hdr_t eh;
        if (!rst) begin
            if (rx_out_valid && rx_out_ready) begin
                if (exp_rx.size() == 0) begin
                    $display("At %0t a beat came out on rx_out with none expected", $time);
                    note_error();
                end else begin
                    compare_beat("rx_out", exp_rx.pop_front(), rx_out);
                end
            end
            if (tx_out_valid && tx_out_ready) begin
                if (exp_tx.size() == 0) begin
                    $display("At %0t a beat came out on tx_out with none expected", $time);
                    note_error();
                end else begin
                    compare_beat("tx_out", exp_tx.pop_front(), tx_out);
                end
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr.size() == 0) begin
                    $display("At %0t a header came out on tx_hdr with none expected", $time);
                    note_error();
                end else begin
                    eh = exp_hdr.pop_front();
                    check_value("tx_hdr.source_ip", eh.source_ip, tx_hdr.source_ip);
                    check_value("tx_hdr.dest_ip", eh.dest_ip, tx_hdr.dest_ip);
                    check_value("tx_hdr.source_port", eh.source_port, tx_hdr.source_port);
                    check_value("tx_hdr.dest_port", eh.dest_port, tx_hdr.dest_port);
                    check_value("tx_hdr.length", eh.length, tx_hdr.length);
                end
            end
        end
    end

endmodule

// ==== sim/udp_connection_tb.sv ====
// UDP connection testbench
`timescale 1ns/1ps

module udp_connection_tb;

    localparam int NUM_ROWS = 9;
    localparam bit DIR_RX = 1'b0;
    localparam bit DIR_TX = 1'b1;
    localparam udp_pkg::port_t    RX_PORT     = 16'd4000;
    localparam udp_pkg::port_t    TX_SRC_PORT = 16'd1234;
    localparam udp_pkg::port_t    TX_DST_PORT = 16'd5678;
    localparam udp_pkg::ip_addr_t LOCAL_IP    = 32'hC0A8_0164;
    localparam udp_pkg::ip_addr_t DEST_IP     = 32'hC0A8_0101;

    typedef struct packed {
        logic           dir;
        udp_pkg::port_t port;
        logic [7:0]     len;
        logic [3:0]     frames;
        logic           stall;
        logic [9:0]     hold;
        logic           deliver;
    } test_row_t;

    // dir, RX port, first length, frames, stalls, header hold cycles, delivered
    // Burst frames grow by 3 bytes each
    test_row_t rows [NUM_ROWS] = '{
        '{DIR_RX, RX_PORT, 8'd5,  4'd1, 1'b0, 10'd0,   1'b1},
        '{DIR_RX, 16'd4001, 8'd7, 4'd1, 1'b0, 10'd0,   1'b0},
        '{DIR_RX, RX_PORT, 8'd12, 4'd1, 1'b0, 10'd0,   1'b1},
        '{DIR_TX, 16'd0,   8'd9,  4'd1, 1'b0, 10'd0,   1'b1},
        '{DIR_TX, 16'd0,   8'd2,  4'd6, 1'b0, 10'd150, 1'b1},
        '{DIR_RX, RX_PORT, 8'd40, 4'd1, 1'b1, 10'd0,   1'b1},
        '{DIR_TX, 16'd0,   8'd33, 4'd1, 1'b1, 10'd0,   1'b1},
        '{DIR_RX, 16'd80,  8'd3,  4'd1, 1'b1, 10'd0,   1'b0},
        '{DIR_RX, RX_PORT, 8'd1,  4'd1, 1'b1, 10'd0,   1'b1}
    };

    string names [NUM_ROWS] = '{
        "rx matching port", "rx other port dropped", "rx match after drop",
        "tx single frame", "tx burst with header hold", "rx with output stalls",
        "tx with output stalls", "rx drop under stalls", "rx single byte"
    };

    logic clk;
    logic rst;
    udp_pkg::udp_cfg_t    cfg;
    udp_pkg::udp_rx_hdr_t rx_hdr;
    logic                 rx_hdr_valid;
    logic                 rx_hdr_ready;
    stream_pkg::beat_t    rx_in;
    logic                 rx_in_valid;
    logic                 rx_in_ready;
    stream_pkg::beat_t    rx_out;
    logic                 rx_out_valid;
    logic                 rx_out_ready;
    stream_pkg::beat_t    tx_in;
    logic                 tx_in_valid;
    logic                 tx_in_ready;
    udp_pkg::udp_tx_hdr_t tx_hdr;
    logic                 tx_hdr_valid;
    logic                 tx_hdr_ready;
    stream_pkg::beat_t    tx_out;
    logic                 tx_out_valid;
    logic                 tx_out_ready;

    integer seed = 97174;
    logic   stall_en = 1'b0;
    int     hold_until = 0;
    int     cycle_count;

    udp_connection #(
        .RX_FIFO_DEPTH   (64),
        .TX_FIFO_DEPTH   (64),
        .LEN_QUEUE_DEPTH (4)
    ) uut (
        .clk (clk), .rst (rst), .cfg (cfg),
        .rx_hdr (rx_hdr), .rx_hdr_valid (rx_hdr_valid), .rx_hdr_ready (rx_hdr_ready),
        .rx_in (rx_in), .rx_in_valid (rx_in_valid), .rx_in_ready (rx_in_ready),
        .rx_out (rx_out), .rx_out_valid (rx_out_valid), .rx_out_ready (rx_out_ready),
        .tx_in (tx_in), .tx_in_valid (tx_in_valid), .tx_in_ready (tx_in_ready),
        .tx_hdr (tx_hdr), .tx_hdr_valid (tx_hdr_valid), .tx_hdr_ready (tx_hdr_ready),
        .tx_out (tx_out), .tx_out_valid (tx_out_valid), .tx_out_ready (tx_out_ready)
    );

    udp_checker chk (
        .clk (clk), .rst (rst), .rx_hdr_ready (rx_hdr_ready),
        .rx_out (rx_out), .rx_out_valid (rx_out_valid), .rx_out_ready (rx_out_ready),
        .tx_out (tx_out), .tx_out_valid (tx_out_valid), .tx_out_ready (tx_out_ready),
        .tx_hdr (tx_hdr), .tx_hdr_valid (tx_hdr_valid), .tx_hdr_ready (tx_hdr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Output side readies with optional random stalls
    // Header ready stays low until the hold ends
    initial begin : ready_drive
        logic [31:0] r;
        rx_out_ready = 1'b0;
        tx_out_ready = 1'b0;
        tx_hdr_ready = 1'b0;
        cycle_count  = 0;
        forever begin
            @(posedge clk);
            #1;
            cycle_count  = cycle_count + 1;
            r            = $random(seed);
            rx_out_ready = !stall_en || r[0];
            tx_out_ready = !stall_en || r[1];
            tx_hdr_ready = (cycle_count >= hold_until) && (!stall_en || r[2]);
        end
    end

    task automatic make_beat(input bit last, output stream_pkg::beat_t b);
        logic [31:0] r;
        r      = $random(seed);
        b.data = r[7:0];
        b.user = r[8];
        b.last = last;
    endtask

    task automatic send_rx_frame(input udp_pkg::port_t port, input int len, input bit deliver);
        stream_pkg::beat_t b;
        rx_hdr.source_ip   = 32'h0A00_0002;
        rx_hdr.source_port = 16'd777;
        rx_hdr.dest_port   = port;
        rx_hdr.length      = udp_pkg::udp_len_t'(len) + udp_pkg::UDP_HDR_LEN;
        rx_hdr_valid       = 1'b1;
        @(negedge clk);
        while (!rx_hdr_ready) @(negedge clk);
        @(posedge clk);
        #1;
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            make_beat(i == len - 1, b);
            if (deliver) chk.expect_rx(b);
            rx_in       = b;
            rx_in_valid = 1'b1;
            @(negedge clk);
            while (!rx_in_ready) @(negedge clk);
            @(posedge clk);
            #1;
        end
        rx_in_valid = 1'b0;
    endtask

    task automatic send_tx_frame(input int len);
        stream_pkg::beat_t    b;
        udp_pkg::udp_tx_hdr_t h;
        h.source_ip   = LOCAL_IP;
        h.dest_ip     = DEST_IP;
        h.source_port = TX_SRC_PORT;
        h.dest_port   = TX_DST_PORT;
        h.length      = udp_pkg::udp_len_t'(len + 8);
        chk.expect_hdr(h);
        for (int i = 0; i < len; i++) begin
            make_beat(i == len - 1, b);
            chk.expect_tx(b);
            tx_in       = b;
            tx_in_valid = 1'b1;
            @(negedge clk);
            while (!tx_in_ready) @(negedge clk);
            @(posedge clk);
            #1;
        end
        tx_in_valid = 1'b0;
    endtask

    initial begin
        rst                = 1'b1;
        cfg.local_ip       = LOCAL_IP;
        cfg.tx_dest_ip     = DEST_IP;
        cfg.tx_source_port = TX_SRC_PORT;
        cfg.tx_dest_port   = TX_DST_PORT;
        cfg.rx_dest_port   = RX_PORT;
        rx_hdr             = '0;
        rx_hdr_valid       = 1'b0;
        rx_in              = '0;
        rx_in_valid        = 1'b0;
        tx_in              = '0;
        tx_in_valid        = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        chk.check_reset_state();
        chk.end_test(0, "state after reset");
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            stall_en   = rows[i].stall;
            hold_until = cycle_count + rows[i].hold;
            for (int f = 0; f < rows[i].frames; f++) begin
                if (rows[i].dir == DIR_TX) begin
                    send_tx_frame(rows[i].len + 3 * f);
                end else begin
                    send_rx_frame(rows[i].port, rows[i].len + 3 * f, rows[i].deliver);
                end
            end
            while (chk.pending() != 0) @(posedge clk);
            // A few idle cycles catch any stray beat
            repeat (4) @(posedge clk);
            #1;
            chk.end_test(i + 1, names[i]);
        end
        chk.report_missing();
        chk.report_counts();
        if (chk.error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int f = 0; f < rows[i].frames; f++) begin
                limit = limit + rows[i].len + 3 * f;
            end
        end
        limit = limit * 20 + 1000;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        chk.report_missing();
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== list.f ====
common/udp_pkg.sv
common/stream_pkg.sv
source/byte_fifo.sv
rx/udp_port_filter.sv
tx/udp_tx_framer.sv
source/udp_connection.sv
sim/udp_checker.sv
sim/udp_connection_tb.sv

// ==== Bender.yml ====
package:
  name: udp_connection

sources:
  - common/udp_pkg.sv
  - common/stream_pkg.sv
  - source/byte_fifo.sv
  - rx/udp_port_filter.sv
  - tx/udp_tx_framer.sv
  - source/udp_connection.sv
  - target: simulation
    files:
      - sim/udp_checker.sv
      - sim/udp_connection_tb.sv
